//--- source/jam_config.svh
`ifndef JAM_CONFIG_SVH
`define JAM_CONFIG_SVH

// matrix geometry
`define JAM_N 8
`define JAM_IDX_W 3

// cost and result widths
`define JAM_COST_W 7
`define JAM_SUM_W 10

// job 0 marks an unassigned row
`define JAM_JOB_W 4

// upper bound on row/column pass rounds
`define JAM_MAX_ROUNDS 8

`endif

//--- source/jam_matrix_pkg.sv
`include "jam_config.svh"

package jam_matrix_pkg;

	// one input cost
	typedef logic [`JAM_COST_W-1:0] cost_t;

	// a full matrix row, element 0 is column 0
	typedef cost_t [`JAM_N-1:0] row_vec_t;

	// one bit per column, set where the reduced cost is zero
	typedef logic [`JAM_N-1:0] zero_mask_t;

	typedef logic [`JAM_SUM_W-1:0] sum_t;
	typedef logic [`JAM_JOB_W-1:0] job_t;

	// one output beat
	typedef struct packed {
		logic valid;
		job_t job;
		sum_t cost;
	} result_t;

endpackage

//--- source/jam_ctrl_pkg.sv
`include "jam_config.svh"

package jam_ctrl_pkg;

	typedef enum logic [2:0] {
		PH_IDLE,
		PH_LOAD,
		PH_COL_SCAN,
		PH_COL_SUB,
		PH_ROW_SCAN,
		PH_ROW_SUB,
		PH_ASSIGN,
		PH_OUTPUT
	} phase_t;

	// commands broadcast to every row lane
	typedef enum logic [2:0] {
		OP_HOLD,
		OP_COL_SUB,
		OP_ROW_SCAN,
		OP_ROW_SUB,
		OP_CLEAR
	} lane_op_t;

	typedef struct packed {
		lane_op_t op;
		logic [`JAM_IDX_W-1:0] scan_idx;
		jam_matrix_pkg::row_vec_t col_min;
	} lane_cmd_t;

endpackage

//--- source/jam_loader.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module jam_loader (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input jam_matrix_pkg::cost_t in_cost,
	input logic accept,
	output jam_matrix_pkg::zero_mask_t load_en,
	output jam_matrix_pkg::row_vec_t load_row,
	output logic load_done
);

	import jam_matrix_pkg::*;

	logic [`JAM_IDX_W-1:0] col_cnt;
	logic [`JAM_IDX_W-1:0] row_cnt;
	row_vec_t row_buf;
	logic sample;

	assign sample = in_valid && accept;
	assign load_row = row_buf;

	// newest cost enters at the top, so column 0 lands in element 0
	always_ff @(posedge clk) begin
		if (sample) begin
			row_buf <= {in_cost, row_buf[`JAM_N-1:1]};
		end
	end

	// ------------------------------------------------------------------
	// column / row counters and lane write strobes
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			col_cnt <= '0;
			row_cnt <= '0;
			load_en <= '0;
			load_done <= 1'b0;
		end else begin
			load_en <= '0;
			load_done <= 1'b0;
			if (sample) begin
				col_cnt <= col_cnt + 1'b1;
				if (col_cnt == `JAM_IDX_W'(`JAM_N - 1)) begin
					load_en[row_cnt] <= 1'b1;
					row_cnt <= row_cnt + 1'b1;
					// last row of the matrix
					load_done <= (row_cnt == `JAM_IDX_W'(`JAM_N - 1));
				end
			end
		end
	end

endmodule

//--- source/jam_controller.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module jam_controller (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic load_done,
	input jam_matrix_pkg::row_vec_t cur_rows [`JAM_N],
	input logic assign_done,
	output logic accept,
	output jam_ctrl_pkg::lane_cmd_t lane_cmd,
	output logic assign_start
);

	import jam_matrix_pkg::*;
	import jam_ctrl_pkg::*;

	phase_t phase;
	phase_t phase_nxt;
	logic [`JAM_IDX_W-1:0] cnt;
	logic [`JAM_IDX_W-1:0] cnt_nxt;
	row_vec_t col_min;
	row_vec_t col_min_nxt;
	logic last;

	assign last = (cnt == `JAM_IDX_W'(`JAM_N - 1));
	assign accept = (phase == PH_IDLE) || (phase == PH_LOAD);

	// ------------------------------------------------------------------
	// phase sequencer
	// ------------------------------------------------------------------
	always_comb begin
		phase_nxt = phase;
		cnt_nxt = cnt;
		case (phase)
			PH_IDLE: begin
				if (in_valid) begin
					phase_nxt = PH_LOAD;
				end
			end
			PH_LOAD: begin
				if (load_done) begin
					phase_nxt = PH_COL_SCAN;
					cnt_nxt = '0;
				end
			end
			PH_COL_SCAN: begin
				cnt_nxt = cnt + 1'b1;
				if (last) begin
					phase_nxt = PH_COL_SUB;
				end
			end
			PH_COL_SUB: phase_nxt = PH_ROW_SCAN;
			PH_ROW_SCAN: begin
				cnt_nxt = cnt + 1'b1;
				if (last) begin
					phase_nxt = PH_ROW_SUB;
				end
			end
			PH_ROW_SUB: phase_nxt = PH_ASSIGN;
			PH_ASSIGN: begin
				if (assign_done) begin
					phase_nxt = PH_IDLE;
				end
			end
			default: phase_nxt = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase <= PH_IDLE;
			cnt <= '0;
			assign_start <= 1'b0;
		end else begin
			phase <= phase_nxt;
			cnt <= cnt_nxt;
			// masks are settled once ROW_SUB has landed
			assign_start <= (phase == PH_ROW_SUB);
		end
	end

	// running element-wise column minimum, one lane per cycle
	always_comb begin
		col_min_nxt = col_min;
		if (phase == PH_COL_SCAN) begin
			for (int j = 0; j < `JAM_N; j++) begin
				if (cnt == '0 || cur_rows[cnt][j] < col_min[j]) begin
					col_min_nxt[j] = cur_rows[cnt][j];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		col_min <= col_min_nxt;
	end

	always_comb begin
		lane_cmd.op = OP_HOLD;
		lane_cmd.scan_idx = cnt;
		lane_cmd.col_min = col_min;
		case (phase)
			PH_IDLE: lane_cmd.op = OP_CLEAR;
			PH_COL_SUB: lane_cmd.op = OP_COL_SUB;
			PH_ROW_SCAN: lane_cmd.op = OP_ROW_SCAN;
			PH_ROW_SUB: lane_cmd.op = OP_ROW_SUB;
			default: lane_cmd.op = OP_HOLD;
		endcase
	end

endmodule

//--- source/jam_row_lane.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module jam_row_lane (
	input logic clk,
	input logic rst_n,
	input logic load_en,
	input jam_matrix_pkg::row_vec_t load_row,
	input jam_ctrl_pkg::lane_cmd_t lane_cmd,
	output jam_matrix_pkg::row_vec_t cur_row,
	output jam_matrix_pkg::row_vec_t orig_row,
	output jam_matrix_pkg::zero_mask_t zero_mask
);

	import jam_matrix_pkg::*;
	import jam_ctrl_pkg::*;

	cost_t row_min;

	// row minimum, rebuilt one column per ROW_SCAN cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_min <= '1;
		end else begin
			case (lane_cmd.op)
				OP_CLEAR: row_min <= '1;
				OP_ROW_SCAN: begin
					if (cur_row[lane_cmd.scan_idx] < row_min) begin
						row_min <= cur_row[lane_cmd.scan_idx];
					end
				end
				default: row_min <= row_min;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// working row and original copy
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (load_en) begin
			cur_row <= load_row;
			orig_row <= load_row;
		end else begin
			case (lane_cmd.op)
				OP_COL_SUB: begin
					for (int j = 0; j < `JAM_N; j++) begin
						cur_row[j] <= cur_row[j] - lane_cmd.col_min[j];
					end
				end
				OP_ROW_SUB: begin
					for (int j = 0; j < `JAM_N; j++) begin
						cur_row[j] <= cur_row[j] - row_min;
					end
				end
				default: cur_row <= cur_row;
			endcase
		end
	end

	always_comb begin
		for (int j = 0; j < `JAM_N; j++) begin
			zero_mask[j] = (cur_row[j] == '0);
		end
	end

endmodule

//--- source/jam_assigner.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module jam_assigner (
	input logic clk,
	input logic rst_n,
	input logic assign_start,
	input jam_matrix_pkg::zero_mask_t zero_masks [`JAM_N],
	input jam_matrix_pkg::row_vec_t orig_rows [`JAM_N],
	output jam_matrix_pkg::result_t result,
	output logic assign_done
);

	import jam_matrix_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_ROW,
		S_COL,
		S_OUT
	} state_t;

	state_t state;
	logic [`JAM_IDX_W-1:0] idx;
	logic [$clog2(`JAM_MAX_ROUNDS+1)-1:0] round;
	logic found;

	// zeros not yet taken, and the per-row picks
	zero_mask_t live [`JAM_N];
	job_t job [`JAM_N];
	sum_t sum;

	zero_mask_t col_live;
	zero_mask_t assigned;
	logic take;
	logic [`JAM_IDX_W-1:0] take_row;
	logic [`JAM_IDX_W-1:0] take_col;
	logic all_done;

	// position of the single set bit
	function automatic logic [`JAM_IDX_W-1:0] one_pos(input zero_mask_t m);
		logic [`JAM_IDX_W-1:0] pos;
		pos = '0;
		for (int i = 0; i < `JAM_N; i++) begin
			if (m[i]) begin
				pos = `JAM_IDX_W'(i);
			end
		end
		return pos;
	endfunction

	always_comb begin
		for (int r = 0; r < `JAM_N; r++) begin
			col_live[r] = live[r][idx];
			assigned[r] = (job[r] != '0);
		end
	end

	// ------------------------------------------------------------------
	// single-zero pick for the current row or column
	// ------------------------------------------------------------------
	always_comb begin
		take = 1'b0;
		take_row = idx;
		take_col = idx;
		if (state == S_ROW && $countones(live[idx]) == 1) begin
			take = 1'b1;
			take_col = one_pos(live[idx]);
		end else if (state == S_COL && $countones(col_live) == 1) begin
			take = 1'b1;
			take_row = one_pos(col_live);
		end
	end

	assign all_done = take && ($countones(assigned) == `JAM_N - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			idx <= '0;
			round <= '0;
			found <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (assign_start) begin
						state <= S_ROW;
						idx <= `JAM_IDX_W'(`JAM_N - 1);
						round <= '0;
						found <= 1'b0;
					end
				end
				S_ROW: begin
					// wraps to 7 for the column pass
					idx <= idx - 1'b1;
					found <= found || take;
					if (all_done) begin
						state <= S_OUT;
						idx <= '0;
					end else if (idx == '0) begin
						state <= S_COL;
					end
				end
				S_COL: begin
					idx <= idx - 1'b1;
					found <= found || take;
					if (all_done) begin
						state <= S_OUT;
						idx <= '0;
					end else if (idx == '0) begin
						found <= 1'b0;
						round <= round + 1'b1;
						if (!(found || take) || round == `JAM_MAX_ROUNDS - 1) begin
							state <= S_OUT;
							idx <= '0;
						end else begin
							state <= S_ROW;
						end
					end
				end
				S_OUT: begin
					idx <= idx + 1'b1;
					if (idx == `JAM_IDX_W'(`JAM_N - 1)) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// taking a zero retires its row and its column
	always_ff @(posedge clk) begin
		if (state == S_IDLE && assign_start) begin
			for (int r = 0; r < `JAM_N; r++) begin
				live[r] <= zero_masks[r];
				job[r] <= '0;
			end
			sum <= '0;
		end else if (take) begin
			for (int r = 0; r < `JAM_N; r++) begin
				if (r == int'(take_row)) begin
					live[r] <= '0;
				end else begin
					live[r][take_col] <= 1'b0;
				end
			end
			job[take_row] <= job_t'(take_col) + 1'b1;
			sum <= sum + sum_t'(orig_rows[take_row][take_col]);
		end
	end

	// ------------------------------------------------------------------
	// result stream, zero outside the burst
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			assign_done <= 1'b0;
		end else begin
			result <= '0;
			assign_done <= 1'b0;
			if (state == S_OUT) begin
				result.valid <= 1'b1;
				result.job <= job[idx];
				result.cost <= sum;
				assign_done <= (idx == `JAM_IDX_W'(`JAM_N - 1));
			end
		end
	end

endmodule

//--- source/jam_top.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module jam_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input jam_matrix_pkg::cost_t in_cost,
	output logic out_valid,
	output jam_matrix_pkg::job_t out_job,
	output jam_matrix_pkg::sum_t out_cost
);

	jam_matrix_pkg::zero_mask_t load_en;
	jam_matrix_pkg::row_vec_t load_row;
	logic load_done;
	logic accept;
	jam_ctrl_pkg::lane_cmd_t lane_cmd;
	logic assign_start;
	logic assign_done;
	jam_matrix_pkg::row_vec_t cur_rows [`JAM_N];
	jam_matrix_pkg::row_vec_t orig_rows [`JAM_N];
	jam_matrix_pkg::zero_mask_t zero_masks [`JAM_N];
	jam_matrix_pkg::result_t result;

	jam_loader i_loader (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_cost(in_cost),
		.accept(accept),
		.load_en(load_en),
		.load_row(load_row),
		.load_done(load_done)
	);

	jam_controller i_controller (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.load_done(load_done),
		.cur_rows(cur_rows),
		.assign_done(assign_done),
		.accept(accept),
		.lane_cmd(lane_cmd),
		.assign_start(assign_start)
	);

	// one lane per matrix row
	for (genvar i = 0; i < `JAM_N; i++) begin : g_lane
		jam_row_lane i_lane (
			.clk(clk),
			.rst_n(rst_n),
			.load_en(load_en[i]),
			.load_row(load_row),
			.lane_cmd(lane_cmd),
			.cur_row(cur_rows[i]),
			.orig_row(orig_rows[i]),
			.zero_mask(zero_masks[i])
		);
	end

	jam_assigner i_assigner (
		.clk(clk),
		.rst_n(rst_n),
		.assign_start(assign_start),
		.zero_masks(zero_masks),
		.orig_rows(orig_rows),
		.result(result),
		.assign_done(assign_done)
	);

	assign out_valid = result.valid;
	assign out_job = result.job;
	assign out_cost = result.cost;

endmodule

//--- testbench/tb_jam_assertions.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module tb_jam_assertions (
	input logic clk,
	input logic rst_n,
	input logic out_valid,
	input jam_matrix_pkg::job_t out_job,
	input jam_matrix_pkg::sum_t out_cost
);

	// beats seen so far in the current burst
	logic [3:0] beat_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (out_valid) begin
			beat_cnt <= beat_cnt + 1'b1;
		end else begin
			beat_cnt <= '0;
		end
	end

	burst_length: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid ? (beat_cnt < 4'(`JAM_N)) : (beat_cnt == 4'd0 || beat_cnt == 4'(`JAM_N)))
		else $error("out_valid burst did not last exactly %0d cycles", `JAM_N);

	cost_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && beat_cnt != 4'd0) |-> $stable(out_cost))
		else $error("out_cost changed inside a burst");

	job_range: assert property (@(posedge clk) disable iff (!rst_n)
		out_job <= 4'(`JAM_N))
		else $error("out_job above %0d", `JAM_N);

endmodule

bind jam_top tb_jam_assertions i_assertions (
	.clk(clk),
	.rst_n(rst_n),
	.out_valid(out_valid),
	.out_job(out_job),
	.out_cost(out_cost)
);

//--- testbench/tb_jam.sv
`timescale 1ns/1ps
`include "jam_config.svh"

module tb_jam;

	import jam_matrix_pkg::*;

	localparam int N = `JAM_N;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 500;

	typedef enum logic [1:0] {
		PAT_DIAG,
		PAT_PERM,
		PAT_CONST,
		PAT_TIED
	} pattern_t;

	// nibble r of perm and jobs belongs to row r
	typedef struct packed {
		pattern_t kind;
		logic [31:0] perm;
		logic [31:0] jobs;
	} test_vec_t;

	logic clk;
	logic rst_n;
	logic in_valid;
	cost_t in_cost;
	logic out_valid;
	job_t out_job;
	sum_t out_cost;

	string test_name [NUM_TESTS];
	test_vec_t test_table [NUM_TESTS];
	int mat [N][N];
	int model_job [N];
	int seed;
	int checks;
	int errors;

	jam_top i_jam_top (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_cost(in_cost),
		.out_valid(out_valid),
		.out_job(out_job),
		.out_cost(out_cost)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("timeout: watchdog stopped the run after %0d cycles",
			NUM_TESTS * CYCLES_PER_TEST);
		$display("Result: FAILED");
		$finish;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic int perm_col(input int t, input int r);
		return int'(test_table[t].perm[4*r +: 3]);
	endfunction

	function automatic int table_job(input int t, input int r);
		return int'(test_table[t].jobs[4*r +: 4]);
	endfunction

	task automatic check_condition(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("Error: %s", what);
		end
	endtask

	task automatic compare_value(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual) else begin
			errors++;
			$display("Mismatch %s: expected %0d, actual %0d", what, expected, actual);
		end
	endtask

	task automatic verify_idle(input int t);
		check_condition(!out_valid && out_job == '0 && out_cost == '0,
			$sformatf("%s: outputs not idle while the matrix is loaded and reduced",
				test_name[t]));
	endtask

	task automatic load_table();
		test_name[0] = "diagonal";
		test_table[0] = '{PAT_DIAG, 32'h76543210, 32'h87654321};
		test_name[1] = "permutation_a";
		test_table[1] = '{PAT_PERM, 32'h25170436, 32'h36281547};
		test_name[2] = "constant";
		test_table[2] = '{PAT_CONST, 32'h76543210, 32'h00000000};
		test_name[3] = "tied_block";
		test_table[3] = '{PAT_TIED, 32'h43627510, 32'h54738600};
		test_name[4] = "permutation_b";
		test_table[4] = '{PAT_PERM, 32'h10325476, 32'h21436587};
		test_name[5] = "permutation_c";
		test_table[5] = '{PAT_PERM, 32'h04615273, 32'h15726384};
	endtask

	task automatic build_matrix(input int t);
		int fill;
		int block;
		fill = rand_range(1, 127);
		block = rand_range(1, 10);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				case (test_table[t].kind)
					PAT_DIAG: mat[r][c] = (c == r) ? 2 + r : rand_range(60, 127);
					PAT_PERM: mat[r][c] = (c == perm_col(t, r)) ? rand_range(1, 10)
						: rand_range(60, 127);
					PAT_CONST: mat[r][c] = fill;
					default: begin
						// rows 0 and 1 share a block of equal costs in columns 0 and 1
						if (r < 2) begin
							mat[r][c] = (c < 2) ? block : rand_range(60, 127);
						end else begin
							mat[r][c] = (c == perm_col(t, r)) ? rand_range(1, 10)
								: rand_range(60, 127);
						end
					end
				endcase
			end
		end
	endtask

	// column then row reduction, then single-zero row and column passes
	task automatic run_model(output int total);
		int red [N][N];
		bit live [N][N];
		int mn;
		int cnt;
		int pick;
		int row;
		int col;
		int taken;
		bit found;
		bit stop;
		for (int c = 0; c < N; c++) begin
			mn = mat[0][c];
			for (int r = 1; r < N; r++) begin
				mn = (mat[r][c] < mn) ? mat[r][c] : mn;
			end
			for (int r = 0; r < N; r++) begin
				red[r][c] = mat[r][c] - mn;
			end
		end
		for (int r = 0; r < N; r++) begin
			mn = red[r][0];
			for (int c = 1; c < N; c++) begin
				mn = (red[r][c] < mn) ? red[r][c] : mn;
			end
			for (int c = 0; c < N; c++) begin
				live[r][c] = (red[r][c] == mn);
			end
			model_job[r] = 0;
		end
		total = 0;
		taken = 0;
		stop = 1'b0;
		for (int round = 0; round < `JAM_MAX_ROUNDS && !stop; round++) begin
			found = 1'b0;
			// pass 0 walks rows, pass 1 walks columns, both from the top index down
			for (int pass = 0; pass < 2 && !stop; pass++) begin
				for (int k = N - 1; k >= 0 && !stop; k--) begin
					cnt = 0;
					pick = 0;
					for (int i = 0; i < N; i++) begin
						if ((pass == 0) ? live[k][i] : live[i][k]) begin
							cnt++;
							pick = i;
						end
					end
					if (cnt == 1) begin
						row = (pass == 0) ? k : pick;
						col = (pass == 0) ? pick : k;
						for (int i = 0; i < N; i++) begin
							live[row][i] = 1'b0;
							live[i][col] = 1'b0;
						end
						model_job[row] = col + 1;
						total += mat[row][col];
						taken++;
						found = 1'b1;
						stop = (taken == N);
					end
				end
			end
			stop = stop || !found;
		end
	endtask

	task automatic apply_matrix(input int t);
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				@(negedge clk);
				verify_idle(t);
				in_valid = 1'b1;
				in_cost = cost_t'(mat[r][c]);
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
		// stray strobes while the matrix is being reduced
		for (int p = 0; p < 3; p++) begin
			repeat (5) begin
				@(negedge clk);
				verify_idle(t);
			end
			in_valid = 1'b1;
			in_cost = cost_t'(rand_range(0, 127));
			@(negedge clk);
			in_valid = 1'b0;
		end
	endtask

	task automatic collect_burst(input int t, input int exp_cost);
		int waited;
		waited = 0;
		while (!out_valid && waited < CYCLES_PER_TEST) begin
			check_condition(out_job == '0 && out_cost == '0,
				$sformatf("%s: outputs not zero while out_valid is low", test_name[t]));
			@(negedge clk);
			waited++;
		end
		check_condition(out_valid, $sformatf("%s: no output burst arrived", test_name[t]));
		if (out_valid) begin
			for (int r = 0; r < N; r++) begin
				if (r > 0) begin
					compare_value($sformatf("%s valid row %0d", test_name[t], r), 1,
						int'(out_valid));
				end
				compare_value($sformatf("%s job row %0d", test_name[t], r), table_job(t, r),
					int'(out_job));
				compare_value($sformatf("%s cost row %0d", test_name[t], r), exp_cost,
					int'(out_cost));
				@(negedge clk);
			end
			check_condition(!out_valid && out_job == '0 && out_cost == '0,
				$sformatf("%s: outputs still driven after eight beats", test_name[t]));
		end
	endtask

	initial begin
		int exp_cost;
		seed = 31083;
		checks = 0;
		errors = 0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_cost = '0;
		load_table();
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_condition(!out_valid && out_job == '0 && out_cost == '0,
				"outputs not zero after reset");
		end

		// ------------------------------------------------------------------
		// one matrix per table entry applied back to back
		// ------------------------------------------------------------------
		for (int t = 0; t < NUM_TESTS; t++) begin
			build_matrix(t);
			run_model(exp_cost);
			for (int r = 0; r < N; r++) begin
				check_condition(model_job[r] == table_job(t, r),
					$sformatf("%s: reference model disagrees with the table at row %0d",
						test_name[t], r));
			end
			apply_matrix(t);
			collect_burst(t, exp_cost);
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- build.f
+incdir+source
source/jam_matrix_pkg.sv
source/jam_ctrl_pkg.sv
source/jam_loader.sv
source/jam_controller.sv
source/jam_row_lane.sv
source/jam_assigner.sv
source/jam_top.sv
testbench/tb_jam_assertions.sv
testbench/tb_jam.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_jam -Mdir obj_dir -f build.f

if ! output=$(./obj_dir/Vtb_jam 2>&1); then
	echo "$output"
	echo "simulation exited with an error status"
	exit 1
fi
echo "$output"
grep -q '^Result: PASSED$' <<< "$output"
